/* include/spi_consts.svh */
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

`define SPI_BYTE_W 8
`define SPI_WORD_W 16
`define SPI_RAM_DEPTH 256

// opcode byte values
`define SPI_OP_DISABLE 8'h00
`define SPI_OP_ENABLE 8'h01
`define SPI_OP_WRITEREG 8'h02
`define SPI_OP_READREG 8'h03
`define SPI_OP_WRITERAM 8'h06
`define SPI_OP_READRAM 8'h07

`endif

/* verilog/spi_proto_pkg.sv */
`include "spi_consts.svh"

package spi_proto_pkg;

    typedef logic [`SPI_BYTE_W-1:0] spi_byte_t;
    typedef logic [`SPI_WORD_W-1:0] spi_word_t;

    // one state per byte position in a frame
    typedef enum logic [4:0] {
        S_IDLE,
        S_DISABLE,
        S_ENABLE,
        S_WREG_ADDR,
        S_WREG_DATA0,
        S_WREG_DATA1,
        S_RREG_ADDR,
        S_RREG_DATA0,
        S_RREG_DATA1,
        S_WRAM_ADDR0,
        S_WRAM_ADDR1,
        S_WRAM_CNT0,
        S_WRAM_CNT1,
        S_WRAM_DATA0,
        S_WRAM_DATA1,
        S_RRAM_ADDR0,
        S_RRAM_ADDR1,
        S_RRAM_CNT0,
        S_RRAM_CNT1,
        S_RRAM_DATA0,
        S_RRAM_DATA1
    } frame_state_t;

endpackage

/* verilog/reg_map_pkg.sv */
`include "spi_consts.svh"

package reg_map_pkg;

    // control register addresses, sum is read only
    typedef enum logic [7:0] {
        REG_SUM  = 8'd0,
        REG_NUM1 = 8'd1,
        REG_NUM2 = 8'd2,
        REG_NUM3 = 8'd3,
        REG_EN   = 8'd4
    } reg_addr_t;

    // index into the word RAM
    typedef logic [$clog2(`SPI_RAM_DEPTH)-1:0] ram_addr_t;

endpackage

/* verilog/spi_byte_slave.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_byte_slave (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     spi_scl,
    input  logic                     spi_sdi,
    input  logic                     spi_sel,
    output logic                     spi_sdo,
    input  spi_proto_pkg::spi_byte_t tx_byte,
    output spi_proto_pkg::spi_byte_t rx_byte,
    output logic                     byte_begin,
    output logic                     byte_end
);
    import spi_proto_pkg::*;

    // two sync stages, the third only keeps history for edges
    logic [2:0] scl_q;
    logic [1:0] sdi_q;
    logic [2:0] sel_q;

    logic sel_act;
    logic sel_fall;
    logic scl_rise;
    logic scl_fall;
    logic last_bit;

    logic [$clog2(`SPI_BYTE_W)-1:0] bit_cnt;
    spi_byte_t rx_sh;
    spi_byte_t tx_sh;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q <= '0;
            sdi_q <= '0;
            sel_q <= '1;
        end else begin
            scl_q <= {scl_q[1:0], spi_scl};
            sdi_q <= {sdi_q[0], spi_sdi};
            sel_q <= {sel_q[1:0], spi_sel};
        end
    end

    assign sel_act  = ~sel_q[1];
    assign sel_fall = ~sel_q[1] & sel_q[2];
    assign scl_rise = sel_act & scl_q[1] & ~scl_q[2];
    assign scl_fall = sel_act & ~scl_q[1] & scl_q[2];
    assign last_bit = (bit_cnt == `SPI_BYTE_W - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            byte_end   <= 1'b0;
            byte_begin <= 1'b0;
        end else begin
            if (!sel_act) begin
                bit_cnt <= '0;
            end else if (scl_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            byte_end   <= scl_rise & last_bit;
            // first byte after select, then back to back
            byte_begin <= sel_fall | (byte_end & sel_act);
        end
    end

    // receive side, msb first on rising scl
    always_ff @(posedge clk) begin
        if (scl_rise) begin
            rx_sh <= {rx_sh[`SPI_BYTE_W-2:0], sdi_q[1]};
            if (last_bit) begin
                rx_byte <= {rx_sh[`SPI_BYTE_W-2:0], sdi_q[1]};
            end
        end
    end

    // transmit side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_sh <= '0;
        end else if (!sel_act) begin
            tx_sh <= '0;
        end else if (byte_begin) begin
            tx_sh <= tx_byte;
        end else if (scl_fall && bit_cnt != 0) begin
            // the fall after the eighth bit belongs to the next byte
            tx_sh <= {tx_sh[`SPI_BYTE_W-2:0], 1'b0};
        end
    end

    assign spi_sdo = tx_sh[`SPI_BYTE_W-1];

endmodule

/* verilog/cmd_parser.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module cmd_parser (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     byte_begin,
    input  logic                     byte_end,
    input  spi_proto_pkg::spi_byte_t rx_byte,
    output spi_proto_pkg::spi_byte_t tx_byte,
    output logic                     en_set,
    output logic                     en_clr,
    output logic                     reg_wr,
    output reg_map_pkg::reg_addr_t   reg_addr,
    output spi_proto_pkg::spi_word_t reg_wdata,
    input  spi_proto_pkg::spi_word_t reg_rdata,
    output logic                     ram_we,
    output spi_proto_pkg::spi_word_t ram_addr,
    output spi_proto_pkg::spi_word_t ram_wdata,
    input  spi_proto_pkg::spi_word_t ram_rdata,
    input  logic                     ram_valid
);
    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    frame_state_t state;
    frame_state_t state_n;

    spi_word_t addr_q;
    spi_word_t cnt_q;
    spi_word_t data_q;
    spi_word_t word_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        if (byte_end) begin
            case (state)
                S_IDLE: begin
                    case (rx_byte)
                        `SPI_OP_DISABLE:  state_n = S_DISABLE;
                        `SPI_OP_ENABLE:   state_n = S_ENABLE;
                        `SPI_OP_WRITEREG: state_n = S_WREG_ADDR;
                        `SPI_OP_READREG:  state_n = S_RREG_ADDR;
                        `SPI_OP_WRITERAM: state_n = S_WRAM_ADDR0;
                        `SPI_OP_READRAM:  state_n = S_RRAM_ADDR0;
                        default:          state_n = S_IDLE;
                    endcase
                end
                S_WREG_ADDR:  state_n = S_WREG_DATA0;
                S_WREG_DATA0: state_n = S_WREG_DATA1;
                S_WREG_DATA1: state_n = S_IDLE;
                S_RREG_ADDR:  state_n = S_RREG_DATA0;
                S_RREG_DATA0: state_n = S_RREG_DATA1;
                S_RREG_DATA1: state_n = S_IDLE;
                S_WRAM_ADDR0: state_n = S_WRAM_ADDR1;
                S_WRAM_ADDR1: state_n = S_WRAM_CNT0;
                S_WRAM_CNT0:  state_n = S_WRAM_CNT1;
                S_WRAM_CNT1:  state_n = S_WRAM_DATA0;
                S_WRAM_DATA0: state_n = S_WRAM_DATA1;
                S_WRAM_DATA1: state_n = (cnt_q == 1) ? S_IDLE : S_WRAM_DATA0;
                S_RRAM_ADDR0: state_n = S_RRAM_ADDR1;
                S_RRAM_ADDR1: state_n = S_RRAM_CNT0;
                S_RRAM_CNT0:  state_n = S_RRAM_CNT1;
                S_RRAM_CNT1:  state_n = S_RRAM_DATA0;
                S_RRAM_DATA0: state_n = S_RRAM_DATA1;
                S_RRAM_DATA1: state_n = (cnt_q == 1) ? S_IDLE : S_RRAM_DATA0;
                default:      state_n = S_IDLE;
            endcase
        end
        // one-byte commands last a single cycle
        if (state == S_DISABLE || state == S_ENABLE) begin
            state_n = S_IDLE;
        end
    end

    // address and count, both high byte first on the wire
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            cnt_q  <= '0;
        end else if (byte_end) begin
            case (state)
                S_WREG_ADDR: begin
                    addr_q <= spi_word_t'(rx_byte);
                end
                S_WRAM_ADDR0, S_RRAM_ADDR0: begin
                    addr_q[`SPI_WORD_W-1:`SPI_BYTE_W] <= rx_byte;
                end
                S_WRAM_ADDR1, S_RRAM_ADDR1: begin
                    addr_q[`SPI_BYTE_W-1:0] <= rx_byte;
                end
                S_WRAM_CNT0, S_RRAM_CNT0: begin
                    cnt_q[`SPI_WORD_W-1:`SPI_BYTE_W] <= rx_byte;
                end
                S_WRAM_CNT1, S_RRAM_CNT1: begin
                    cnt_q[`SPI_BYTE_W-1:0] <= rx_byte;
                end
                S_WRAM_DATA1, S_RRAM_DATA1: begin
                    // count of 0 wraps, so it runs 65536 words
                    addr_q <= addr_q + 1'b1;
                    cnt_q  <= cnt_q - 1'b1;
                end
                default: ;
            endcase
        end
    end

    // read word captured at the address byte, or low byte of a write
    always_ff @(posedge clk) begin
        if (byte_end) begin
            if (state == S_RREG_ADDR) begin
                data_q <= reg_rdata;
            end else if (state == S_WREG_DATA0 || state == S_WRAM_DATA0) begin
                data_q[`SPI_BYTE_W-1:0] <= rx_byte;
            end
        end
    end

    // words arrive low byte first
    assign word_in   = {rx_byte, data_q[`SPI_BYTE_W-1:0]};
    assign reg_wdata = word_in;
    assign ram_wdata = word_in;
    assign ram_addr  = addr_q;

    assign reg_addr = (state == S_RREG_ADDR) ? reg_addr_t'(rx_byte)
                                             : reg_addr_t'(addr_q[`SPI_BYTE_W-1:0]);

    assign reg_wr = byte_end && (state == S_WREG_DATA1);
    assign ram_we = byte_end && (state == S_WRAM_DATA1) && ram_valid;
    assign en_set = (state == S_ENABLE);
    assign en_clr = (state == S_DISABLE);

    // response byte, only shown while the slave loads it
    always_comb begin
        tx_byte = '0;
        if (byte_begin) begin
            case (state)
                S_RREG_DATA0: tx_byte = data_q[`SPI_BYTE_W-1:0];
                S_RREG_DATA1: tx_byte = data_q[`SPI_WORD_W-1:`SPI_BYTE_W];
                S_RRAM_DATA0: begin
                    tx_byte = ram_valid ? ram_rdata[`SPI_BYTE_W-1:0] : '0;
                end
                S_RRAM_DATA1: begin
                    tx_byte = ram_valid ? ram_rdata[`SPI_WORD_W-1:`SPI_BYTE_W] : '0;
                end
                default: tx_byte = '0;
            endcase
        end
    end

endmodule

/* verilog/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  spi_proto_pkg::spi_word_t sum,
    input  logic                     en_set,
    input  logic                     en_clr,
    input  logic                     reg_wr,
    input  reg_map_pkg::reg_addr_t   reg_addr,
    input  spi_proto_pkg::spi_word_t reg_wdata,
    output spi_proto_pkg::spi_word_t reg_rdata,
    output spi_proto_pkg::spi_word_t num1,
    output spi_proto_pkg::spi_word_t num2,
    output spi_proto_pkg::spi_word_t num3,
    output logic                     en
);
    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num1 <= '0;
            num2 <= '0;
            num3 <= '0;
            en   <= 1'b0;
        end else begin
            if (en_set) begin
                en <= 1'b1;
            end else if (en_clr) begin
                en <= 1'b0;
            end
            // sum and en are not writable here
            if (reg_wr) begin
                case (reg_addr)
                    REG_NUM1: num1 <= reg_wdata;
                    REG_NUM2: num2 <= reg_wdata;
                    REG_NUM3: num3 <= reg_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_addr)
            REG_SUM:  reg_rdata = sum;
            REG_NUM1: reg_rdata = num1;
            REG_NUM2: reg_rdata = num2;
            REG_NUM3: reg_rdata = num3;
            REG_EN:   reg_rdata = spi_word_t'(en);
            default:  reg_rdata = '0;
        endcase
    end

endmodule

/* verilog/word_ram.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module word_ram #(
    parameter int depth = `SPI_RAM_DEPTH
) (
    input  logic                     clk,
    input  logic                     we,
    input  spi_proto_pkg::spi_word_t addr,
    input  spi_proto_pkg::spi_word_t wdata,
    output spi_proto_pkg::spi_word_t rdata,
    output logic                     valid
);
    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    spi_word_t mem [depth];
    ram_addr_t idx;

    // upper address bits only matter for the range check
    assign valid = (addr < depth);
    assign idx   = addr[$bits(ram_addr_t)-1:0];

    always_ff @(posedge clk) begin
        if (we && valid) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = valid ? mem[idx] : '0;

endmodule

/* verilog/spi_ctrl_top.sv */
`timescale 1ns/1ps

module spi_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     spi_scl,
    input  logic                     spi_sdi,
    input  logic                     spi_sel,
    output logic                     spi_sdo,
    input  spi_proto_pkg::spi_word_t sum,
    output spi_proto_pkg::spi_word_t num1,
    output spi_proto_pkg::spi_word_t num2,
    output spi_proto_pkg::spi_word_t num3,
    output logic                     en
);
    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    spi_byte_t tx_byte;
    spi_byte_t rx_byte;
    logic      byte_begin;
    logic      byte_end;

    logic      en_set;
    logic      en_clr;
    logic      reg_wr;
    reg_addr_t reg_addr;
    spi_word_t reg_wdata;
    spi_word_t reg_rdata;

    logic      ram_we;
    logic      ram_valid;
    spi_word_t ram_addr;
    spi_word_t ram_wdata;
    spi_word_t ram_rdata;

    spi_byte_slave spi_byte_slave_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi_scl    (spi_scl),
        .spi_sdi    (spi_sdi),
        .spi_sel    (spi_sel),
        .spi_sdo    (spi_sdo),
        .tx_byte    (tx_byte),
        .rx_byte    (rx_byte),
        .byte_begin (byte_begin),
        .byte_end   (byte_end)
    );

    cmd_parser cmd_parser_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_begin (byte_begin),
        .byte_end   (byte_end),
        .rx_byte    (rx_byte),
        .tx_byte    (tx_byte),
        .en_set     (en_set),
        .en_clr     (en_clr),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .ram_valid  (ram_valid)
    );

    ctrl_regs ctrl_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum       (sum),
        .en_set    (en_set),
        .en_clr    (en_clr),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .num1      (num1),
        .num2      (num2),
        .num3      (num3),
        .en        (en)
    );

    word_ram word_ram_inst (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata),
        .valid (ram_valid)
    );

endmodule

/* test/spi_ctrl_assert.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_ctrl_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     byte_begin,
    input logic                     byte_end,
    input logic                     ram_we,
    input spi_proto_pkg::spi_word_t ram_addr,
    input logic                     en,
    input logic                     spi_sdo
);
    int assert_fails = 0;

    begin_end_apart: assert property (
        @(posedge clk) disable iff (!rst_n) !(byte_begin && byte_end)
    ) else begin
        assert_fails++;
        $error("byte_begin and byte_end fired in the same cycle");
    end

    // checked against the address itself, not the RAM's own valid
    ram_we_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) ram_we |-> (ram_addr < `SPI_RAM_DEPTH)
    ) else begin
        assert_fails++;
        $error("ram_we raised for an out-of-range address");
    end

    outputs_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown({en, spi_sdo})
    ) else begin
        assert_fails++;
        $error("en or spi_sdo is unknown");
    end

endmodule

bind spi_ctrl_top spi_ctrl_assert spi_ctrl_assert_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_begin (byte_begin),
    .byte_end   (byte_end),
    .ram_we     (ram_we),
    .ram_addr   (ram_addr),
    .en         (en),
    .spi_sdo    (spi_sdo)
);

/* test/tb_spi_ctrl.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module tb_spi_ctrl;
    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    localparam int HALF = 4;
    localparam int BYTE_LIMIT = 32;

    logic      clk;
    logic      rst_n;
    logic      spi_scl;
    logic      spi_sdi;
    logic      spi_sel;
    logic      spi_sdo;
    spi_word_t sum;
    spi_word_t num1;
    spi_word_t num2;
    spi_word_t num3;
    logic      en;

    integer seed = 32'h81de_cdb6;
    int     byte_errors = 0;
    int     port_errors = 0;
    event   frame_done;

    // reference copy of the register bank and RAM
    spi_word_t m_num [1:3];
    logic      m_en;
    spi_word_t m_ram [`SPI_RAM_DEPTH];

    spi_byte_t tx_q[$];
    spi_byte_t rx_q[$];
    spi_byte_t exp_q[$];

    spi_ctrl_top spi_ctrl_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .spi_scl (spi_scl),
        .spi_sdi (spi_sdi),
        .spi_sel (spi_sel),
        .spi_sdo (spi_sdo),
        .sum     (sum),
        .num1    (num1),
        .num2    (num2),
        .num3    (num3),
        .en      (en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            tick();
        end
    endtask

    task automatic wait_byte_end();
        int n;
        n = 0;
        while (!spi_ctrl_top_inst.byte_end && n < BYTE_LIMIT) begin
            tick();
            n++;
        end
        if (!spi_ctrl_top_inst.byte_end) begin
            $display("timeout: no byte_end after the eighth SCL edge");
            $display("Simulation failed");
            $finish;
        end
    endtask

    function automatic spi_word_t reg_model(input spi_byte_t addr);
        case (addr)
            8'd0:             return sum;
            8'd1, 8'd2, 8'd3: return m_num[addr];
            8'd4:             return {15'b0, m_en};
            default:          return '0;
        endcase
    endfunction

    // expected response bytes of the frame in tx_q and the model update
    function automatic void predict_frame();
        int        a;
        int        cnt;
        spi_word_t w;
        exp_q = {};
        foreach (tx_q[i]) begin
            exp_q.push_back(8'h00);
        end
        case (tx_q[0])
            `SPI_OP_DISABLE: m_en = 1'b0;
            `SPI_OP_ENABLE:  m_en = 1'b1;
            `SPI_OP_WRITEREG: begin
                if (tx_q[1] >= 1 && tx_q[1] <= 3) begin
                    m_num[tx_q[1]] = {tx_q[3], tx_q[2]};
                end
            end
            `SPI_OP_READREG: begin
                w = reg_model(tx_q[1]);
                exp_q[2] = w[7:0];
                exp_q[3] = w[15:8];
            end
            `SPI_OP_WRITERAM, `SPI_OP_READRAM: begin
                a = {tx_q[1], tx_q[2]};
                cnt = {tx_q[3], tx_q[4]};
                for (int i = 0; i < cnt; i++) begin
                    if (tx_q[0] == `SPI_OP_WRITERAM) begin
                        if (a + i < `SPI_RAM_DEPTH) begin
                            m_ram[a + i] = {tx_q[6 + 2 * i], tx_q[5 + 2 * i]};
                        end
                    end else begin
                        // out of range reads back as zero
                        w = (a + i < `SPI_RAM_DEPTH) ? m_ram[a + i] : '0;
                        exp_q[5 + 2 * i] = w[7:0];
                        exp_q[6 + 2 * i] = w[15:8];
                    end
                end
            end
            default: ;
        endcase
    endfunction

    // mode 0 master samples sdo just before each rising SCL
    task automatic xfer_byte(input spi_byte_t tx, output spi_byte_t rx);
        for (int i = 7; i >= 0; i--) begin
            spi_sdi = tx[i];
            wait_cycles(HALF);
            rx[i] = spi_sdo;
            spi_scl = 1'b1;
            if (i == 0) begin
                wait_byte_end();
                tick();
            end else begin
                wait_cycles(HALF);
            end
            spi_scl = 1'b0;
        end
    endtask

    task automatic run_frame();
        spi_byte_t rx;
        spi_sel = 1'b0;
        wait_cycles(HALF);
        // compare of the previous frame is done by now
        rx_q = {};
        foreach (tx_q[i]) begin
            xfer_byte(tx_q[i], rx);
            rx_q.push_back(rx);
        end
        spi_sel = 1'b1;
        wait_cycles(2 * HALF);
        predict_frame();
        -> frame_done;
    endtask

    task automatic one_byte(input spi_byte_t op);
        tx_q = {op};
        run_frame();
    endtask

    task automatic write_reg(input spi_byte_t addr, input spi_word_t data);
        tx_q = {`SPI_OP_WRITEREG, addr, data[7:0], data[15:8]};
        run_frame();
    endtask

    task automatic read_reg(input spi_byte_t addr);
        tx_q = {`SPI_OP_READREG, addr, 8'h00, 8'h00};
        run_frame();
    endtask

    task automatic ram_frame(input spi_byte_t op, input spi_word_t addr, input spi_word_t cnt);
        spi_word_t w;
        tx_q = {op, addr[15:8], addr[7:0], cnt[15:8], cnt[7:0]};
        for (int i = 0; i < cnt; i++) begin
            w = (op == `SPI_OP_WRITERAM) ? spi_word_t'($random(seed)) : '0;
            tx_q.push_back(w[7:0]);
            tx_q.push_back(w[15:8]);
        end
        run_frame();
    endtask

    task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            port_errors++;
        end
    endtask

    task automatic check_ports();
        check_word("num1", num1, m_num[1]);
        check_word("num2", num2, m_num[2]);
        check_word("num3", num3, m_num[3]);
        check_word("en", {15'b0, en}, {15'b0, m_en});
    endtask

    initial begin
        forever begin
            @(frame_done);
            foreach (exp_q[i]) begin
                if (rx_q[i] !== exp_q[i]) begin
                    $display("FAILED spi_sdo byte %0d: got %h expected %h",
                             i, rx_q[i], exp_q[i]);
                    byte_errors++;
                end
            end
        end
    end

    initial begin
        spi_word_t data;
        spi_word_t start;
        int        fails;
        rst_n = 1'b0;
        spi_scl = 1'b0;
        spi_sdi = 1'b0;
        spi_sel = 1'b1;
        sum = '0;
        m_en = 1'b0;
        foreach (m_num[i]) begin
            m_num[i] = '0;
        end
        foreach (m_ram[i]) begin
            m_ram[i] = '0;
        end
        wait_cycles(16);
        rst_n = 1'b1;
        sum = $random(seed);
        wait_cycles(4);
        check_ports();
        check_word("spi_sdo", {15'b0, spi_sdo}, 16'h0000);

        one_byte(`SPI_OP_ENABLE);
        check_ports();
        read_reg(REG_EN);
        one_byte(`SPI_OP_DISABLE);
        check_ports();
        read_reg(REG_EN);

        for (int r = 1; r <= 3; r++) begin
            data = $random(seed);
            write_reg(8'(r), data);
        end
        check_ports();
        data = $random(seed);
        write_reg(REG_SUM, data);
        check_ports();
        for (int r = 0; r <= 4; r++) begin
            read_reg(8'(r));
        end
        read_reg(8'd9);

        // burst inside the RAM
        start = $random(seed) & 16'h00f0;
        ram_frame(`SPI_OP_WRITERAM, start, 16'd8);
        ram_frame(`SPI_OP_READRAM, start, 16'd8);

        // burst running off the end
        ram_frame(`SPI_OP_WRITERAM, 16'd254, 16'd4);
        ram_frame(`SPI_OP_READRAM, 16'd254, 16'd4);
        ram_frame(`SPI_OP_READRAM, 16'd300, 16'd2);

        one_byte(8'h04);
        data = $random(seed);
        write_reg(REG_NUM2, data);
        read_reg(REG_NUM2);
        one_byte(8'h09);
        data = $random(seed);
        write_reg(REG_NUM1, data);
        read_reg(REG_NUM1);
        check_ports();

        wait_cycles(4);
        fails = spi_ctrl_top_inst.spi_ctrl_assert_inst.assert_fails;
        $display("errors: %0d response, %0d port, %0d assertion",
                 byte_errors, port_errors, fails);
        if (byte_errors + port_errors + fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
verilog/spi_proto_pkg.sv
verilog/reg_map_pkg.sv
verilog/spi_byte_slave.sv
verilog/cmd_parser.sv
verilog/ctrl_regs.sv
verilog/word_ram.sv
verilog/spi_ctrl_top.sv
test/spi_ctrl_assert.sv
test/tb_spi_ctrl.sv

/* Bender.yml */
package:
  name: spi_ctrl

sources:
  - include_dirs:
      - include
    files:
      - verilog/spi_proto_pkg.sv
      - verilog/reg_map_pkg.sv
      - verilog/spi_byte_slave.sv
      - verilog/cmd_parser.sv
      - verilog/ctrl_regs.sv
      - verilog/word_ram.sv
      - verilog/spi_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/spi_ctrl_assert.sv
      - test/tb_spi_ctrl.sv
